// File: Makefile
TOP = rms_norm_2d_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP)

obj_dir/V$(TOP): build.f source/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f

lint:
	verilator --lint-only --timing --assert -Wall -Wno-fatal --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

// File: build.f
source/norm_fmt_pkg.sv
source/norm_stream_pkg.sv
source/block_fifo.sv
source/square_accumulator.sv
source/inv_sqrt_serial.sv
source/scale_apply.sv
source/rms_norm_2d.sv
verification/rms_norm_2d_props.sv
verification/rms_norm_2d_tb.sv

// File: source/block_fifo.sv
// Block FIFO

`timescale 1ns/100ps

module block_fifo #(
    parameter type payload_t = norm_stream_pkg::act_block_t,
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (rd_en) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= in_data;
    end

endmodule

// File: source/inv_sqrt_serial.sv
// Bit-serial inverse square root

`timescale 1ns/100ps

module inv_sqrt_serial (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       in_valid,
    output logic                       in_ready,
    input  norm_stream_pkg::mean_sq_t  in_data,

    output logic                       out_valid,
    input  logic                       out_ready,
    output norm_stream_pkg::inv_root_t out_data
);

    localparam int RW     = norm_fmt_pkg::ISQRT_WIDTH;
    localparam int MW     = norm_fmt_pkg::ACC_WIDTH;
    localparam int PROD_W = 2 * RW + MW;
    localparam int CNT_W  = $clog2(RW + 1);

    // Unity in the R^2 * M product format
    localparam logic [PROD_W-1:0] LIMIT = PROD_W'(1) << norm_fmt_pkg::ISQRT_ONE_EXP;

    logic [MW-1:0]     mean_q;
    logic [RW-1:0]     root_q;
    logic [CNT_W-1:0]  bit_cnt;
    logic [CNT_W-1:0]  bit_idx;
    logic              busy;
    logic [RW-1:0]     trial;
    logic [2*RW-1:0]   trial_sq;
    logic [PROD_W-1:0] trial_prod;

    assign in_ready = !busy && !out_valid;

    // Candidate with the current bit set
    assign bit_idx    = bit_cnt - 1'b1;
    assign trial      = root_q | (RW'(1) << bit_idx);
    assign trial_sq   = trial * trial;
    assign trial_prod = trial_sq * mean_q;

    // MSB first, one bit per cycle, then one cycle to raise out_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            out_valid <= 1'b0;
            bit_cnt   <= '0;
            root_q    <= '0;
        end else begin
            if (in_valid && in_ready) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_W'(RW);
                root_q  <= '0;
            end else if (busy) begin
                if (bit_cnt != '0) begin
                    bit_cnt <= bit_cnt - 1'b1;
                    // Keep the bit while R^2 * M stays at or below one
                    if (trial_prod <= LIMIT) root_q <= trial;
                end else begin
                    busy      <= 1'b0;
                    out_valid <= 1'b1;
                end
            end else if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) mean_q <= in_data.mean;
    end

    // A zero mean keeps every bit and yields all ones
    assign out_data.root = root_q;

endmodule

// File: source/norm_fmt_pkg.sv
// RMS norm fixed-point formats

package norm_fmt_pkg;

    // Lanes per block
    localparam int LANES = 4;

    // Activation input
    localparam int IN_WIDTH = 8;
    localparam int IN_FRAC  = 2;

    // Per-lane weight
    localparam int SCALE_WIDTH = 8;
    localparam int SCALE_FRAC  = 2;

    // Normalized output
    localparam int OUT_WIDTH = 8;
    localparam int OUT_FRAC  = 4;

    // Largest group length the accumulator width covers
    localparam int MAX_ITERS = 16;

    // One squared lane and the group sum
    localparam int SQ_WIDTH  = 2 * IN_WIDTH;
    localparam int SQ_FRAC   = 2 * IN_FRAC;
    localparam int ACC_WIDTH = SQ_WIDTH + $clog2(LANES) + $clog2(MAX_ITERS);
    localparam int ACC_FRAC  = SQ_FRAC;

    // Unsigned inverse root, R^2 * M is compared against 2^ISQRT_ONE_EXP
    localparam int ISQRT_WIDTH   = 16;
    localparam int ISQRT_FRAC    = 14;
    localparam int ISQRT_ONE_EXP = 2 * ISQRT_FRAC + ACC_FRAC;

    // Activation x root x weight product down to the output format
    localparam int PROD_FRAC = IN_FRAC + ISQRT_FRAC + SCALE_FRAC;
    localparam int OUT_SHIFT = PROD_FRAC - OUT_FRAC;

endpackage

// File: source/norm_stream_pkg.sv
// RMS norm stream payloads

package norm_stream_pkg;

    // Raw activations, one signed value per lane
    typedef struct packed {
        logic [norm_fmt_pkg::LANES-1:0][norm_fmt_pkg::IN_WIDTH-1:0] lane;
    } act_block_t;

    // Signed weights applied after normalization
    typedef struct packed {
        logic [norm_fmt_pkg::LANES-1:0][norm_fmt_pkg::SCALE_WIDTH-1:0] lane;
    } weight_block_t;

    // Mean of squares for one group
    typedef struct packed {
        logic [norm_fmt_pkg::ACC_WIDTH-1:0] mean;
    } mean_sq_t;

    // Inverse root of the mean, unsigned
    typedef struct packed {
        logic [norm_fmt_pkg::ISQRT_WIDTH-1:0] root;
    } inv_root_t;

    // Normalized and saturated result
    typedef struct packed {
        logic [norm_fmt_pkg::LANES-1:0][norm_fmt_pkg::OUT_WIDTH-1:0] lane;
    } out_block_t;

endpackage

// File: source/rms_norm_2d.sv
// RMS normalization top level

`timescale 1ns/100ps

module rms_norm_2d #(
    parameter int NUM_ITERS  = 4,
    parameter int FIFO_DEPTH = 2 * NUM_ITERS
) (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          in_valid,
    output logic                          in_ready,
    input  norm_stream_pkg::act_block_t   in_data,

    input  logic                          weight_valid,
    output logic                          weight_ready,
    input  norm_stream_pkg::weight_block_t weight_data,

    output logic                          out_valid,
    input  logic                          out_ready,
    output norm_stream_pkg::out_block_t   out_data
);

    logic                        fifo_in_valid;
    logic                        fifo_in_ready;
    logic                        fifo_out_valid;
    logic                        fifo_out_ready;
    norm_stream_pkg::act_block_t fifo_out_data;
    logic                        sq_in_valid;
    logic                        sq_in_ready;
    logic                        mean_valid;
    logic                        mean_ready;
    norm_stream_pkg::mean_sq_t   mean_data;
    logic                        root_valid;
    logic                        root_ready;
    norm_stream_pkg::inv_root_t  root_data;

    // Fork so the FIFO and the statistics take each beat together
    assign in_ready      = fifo_in_ready && sq_in_ready;
    assign fifo_in_valid = in_valid && sq_in_ready;
    assign sq_in_valid   = in_valid && fifo_in_ready;

    block_fifo #(
        .payload_t (norm_stream_pkg::act_block_t),
        .DEPTH     (FIFO_DEPTH)
    ) block_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .in_data   (in_data),
        .out_valid (fifo_out_valid),
        .out_ready (fifo_out_ready),
        .out_data  (fifo_out_data)
    );

    square_accumulator #(
        .NUM_ITERS (NUM_ITERS)
    ) square_accumulator_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sq_in_valid),
        .in_ready  (sq_in_ready),
        .in_data   (in_data),
        .out_valid (mean_valid),
        .out_ready (mean_ready),
        .out_data  (mean_data)
    );

    inv_sqrt_serial inv_sqrt_serial_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mean_valid),
        .in_ready  (mean_ready),
        .in_data   (mean_data),
        .out_valid (root_valid),
        .out_ready (root_ready),
        .out_data  (root_data)
    );

    scale_apply #(
        .NUM_ITERS    (NUM_ITERS)
    ) scale_apply_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .root_valid   (root_valid),
        .root_ready   (root_ready),
        .root_data    (root_data),
        .act_valid    (fifo_out_valid),
        .act_ready    (fifo_out_ready),
        .act_data     (fifo_out_data),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .weight_data  (weight_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

endmodule

// File: source/scale_apply.sv
// Inverse root and weight scaling

`timescale 1ns/100ps

module scale_apply #(
    parameter int NUM_ITERS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          root_valid,
    output logic                          root_ready,
    input  norm_stream_pkg::inv_root_t    root_data,

    input  logic                          act_valid,
    output logic                          act_ready,
    input  norm_stream_pkg::act_block_t   act_data,

    input  logic                          weight_valid,
    output logic                          weight_ready,
    input  norm_stream_pkg::weight_block_t weight_data,

    output logic                          out_valid,
    input  logic                          out_ready,
    output norm_stream_pkg::out_block_t   out_data
);

    localparam int LANES   = norm_fmt_pkg::LANES;
    localparam int R_W     = norm_fmt_pkg::ISQRT_WIDTH;
    localparam int NORM_W  = norm_fmt_pkg::IN_WIDTH + R_W + 1;
    localparam int PROD_W  = NORM_W + norm_fmt_pkg::SCALE_WIDTH;
    localparam int SHIFT_W = PROD_W - norm_fmt_pkg::OUT_SHIFT;
    localparam int OUT_W   = norm_fmt_pkg::OUT_WIDTH;
    localparam int CNT_W   = (NUM_ITERS > 1) ? $clog2(NUM_ITERS) : 1;

    localparam logic signed [SHIFT_W-1:0] OUT_MAX = SHIFT_W'((1 << (OUT_W - 1)) - 1);
    localparam logic signed [SHIFT_W-1:0] OUT_MIN = SHIFT_W'(-(1 << (OUT_W - 1)));

    logic [R_W-1:0]                 root_q;
    logic                           group_active;
    logic [CNT_W-1:0]               join_cnt;
    logic                           last_join;
    logic                           join_fire;
    logic                           s1_ready;
    logic                           s2_ready;
    logic                           s1_valid;
    logic signed [NORM_W-1:0]       s1_norm [LANES];
    norm_stream_pkg::weight_block_t s1_weight;
    logic signed [PROD_W-1:0]       s2_prod [LANES];
    logic signed [SHIFT_W-1:0]      s2_shift [LANES];
    norm_stream_pkg::out_block_t    out_next;

    function automatic logic [OUT_W-1:0] saturate(input logic signed [SHIFT_W-1:0] v);
        logic [OUT_W-1:0] res;
        if (v > OUT_MAX) res = OUT_MAX[OUT_W-1:0];
        else if (v < OUT_MIN) res = OUT_MIN[OUT_W-1:0];
        else res = v[OUT_W-1:0];
        return res;
    endfunction

    // Stages stall in place, the join waits on stage 1
    assign s2_ready = !out_valid || out_ready;
    assign s1_ready = !s1_valid || s2_ready;

    assign root_ready   = !group_active;
    assign join_fire    = group_active && act_valid && weight_valid && s1_ready;
    assign act_ready    = group_active && weight_valid && s1_ready;
    assign weight_ready = group_active && act_valid && s1_ready;
    assign last_join    = (join_cnt == CNT_W'(NUM_ITERS - 1));

    // Stage 2 math, arithmetic shift gives the floor
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            s2_prod[i]      = s1_norm[i] * $signed(s1_weight.lane[i]);
            s2_shift[i]     = SHIFT_W'(s2_prod[i] >>> norm_fmt_pkg::OUT_SHIFT);
            out_next.lane[i] = saturate(s2_shift[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            group_active <= 1'b0;
            join_cnt     <= '0;
            s1_valid     <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            if (root_valid && root_ready) group_active <= 1'b1;
            else if (join_fire && last_join) group_active <= 1'b0;
            if (join_fire) join_cnt <= last_join ? '0 : join_cnt + 1'b1;
            if (s1_ready) s1_valid <= join_fire;
            if (s2_ready) out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (root_valid && root_ready) root_q <= root_data.root;
        if (join_fire) begin
            // Root is unsigned, widen with a zero sign bit
            for (int i = 0; i < LANES; i++) begin
                s1_norm[i] <= $signed(act_data.lane[i]) * $signed({1'b0, root_q});
            end
            s1_weight <= weight_data;
        end
        if (s2_ready && s1_valid) out_data <= out_next;
    end

endmodule

// File: source/square_accumulator.sv
// Group mean of squares

`timescale 1ns/100ps

module square_accumulator #(
    parameter int NUM_ITERS = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  norm_stream_pkg::act_block_t in_data,

    output logic                      out_valid,
    input  logic                      out_ready,
    output norm_stream_pkg::mean_sq_t out_data
);

    localparam int LANES = norm_fmt_pkg::LANES;
    localparam int SQ_W  = norm_fmt_pkg::SQ_WIDTH;
    localparam int SUM_W = SQ_W + $clog2(LANES);
    localparam int ACC_W = norm_fmt_pkg::ACC_WIDTH;
    localparam int CNT_W = (NUM_ITERS > 1) ? $clog2(NUM_ITERS) : 1;

    // floor(2^ACC_W / values per group), applied as multiply then shift
    localparam logic [ACC_W:0] RECIP = (ACC_W + 1)'((1 << ACC_W) / (LANES * NUM_ITERS));

    logic [SQ_W-1:0]    lane_sq [LANES];
    logic [SUM_W-1:0]   lane_sum;
    logic [ACC_W-1:0]   acc_q;
    logic [ACC_W-1:0]   acc_next;
    logic [2*ACC_W:0]   scaled;
    logic [ACC_W-1:0]   mean_q;
    logic [CNT_W-1:0]   beat_cnt;
    logic               in_fire;
    logic               last_beat;

    // Result must leave before the next beat is taken
    assign in_ready  = !out_valid || out_ready;
    assign in_fire   = in_valid && in_ready;
    assign last_beat = (beat_cnt == CNT_W'(NUM_ITERS - 1));

    // Squares are never negative, so the sum stays unsigned
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            lane_sq[i] = SQ_W'($signed(in_data.lane[i]) * $signed(in_data.lane[i]));
            lane_sum   = lane_sum + SUM_W'(lane_sq[i]);
        end
    end

    assign acc_next = acc_q + ACC_W'(lane_sum);
    assign scaled   = acc_next * RECIP;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q     <= '0;
            beat_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) out_valid <= 1'b0;
            if (in_fire) begin
                if (last_beat) begin
                    // Start the next group from zero
                    acc_q     <= '0;
                    beat_cnt  <= '0;
                    out_valid <= 1'b1;
                end else begin
                    acc_q    <= acc_next;
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // Floor of the scaled sum
    always_ff @(posedge clk) begin
        if (in_fire && last_beat) mean_q <= scaled[ACC_W +: ACC_W];
    end

    assign out_data.mean = mean_q;

endmodule

// File: verification/rms_norm_2d_props.sv
// RMS norm protocol properties

`timescale 1ns/100ps

module rms_norm_2d_props #(
    parameter int DEPTH = 8
) (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        in_valid,
    input logic                        in_ready,
    input logic                        fifo_out_valid,
    input logic                        fifo_out_ready,
    input logic                        out_valid,
    input logic                        out_ready,
    input norm_stream_pkg::out_block_t out_data
);

    // Blocks held in the FIFO, counted from the handshakes at its ports
    int held;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= 0;
        end else begin
            held <= held + int'(in_valid && in_ready)
                         - int'(fifo_out_valid && fifo_out_ready);
        end
    end

    // Stalled output holds its value
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_valid or out_data changed while the output was stalled");

    // Full FIFO blocks the input
    full_blocks_input: assert property (@(posedge clk) disable iff (!rst_n)
        held == DEPTH |-> !in_ready)
        else $error("in_ready was high while the block FIFO was full");

    out_low_in_reset: assert property (@(posedge clk)
        !rst_n |-> !out_valid)
        else $error("out_valid was high during reset");

    // First cycle out of reset
    out_low_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !out_valid)
        else $error("out_valid was high on the first cycle after reset");

    out_valid_known: assert property (@(posedge clk)
        rst_n |-> !$isunknown(out_valid))
        else $error("out_valid was unknown after reset");

endmodule

// File: verification/rms_norm_2d_tb.sv
// RMS norm testbench

`timescale 1ns/100ps

module rms_norm_2d_tb;

    localparam int NUM_ITERS   = 4;
    localparam int LANES       = norm_fmt_pkg::LANES;
    localparam int NUM_GROUPS  = 13;
    localparam int TOTAL_BEATS = NUM_GROUPS * NUM_ITERS;
    localparam int CYCLE_LIMIT =
        NUM_GROUPS * (NUM_ITERS * 4 + norm_fmt_pkg::ISQRT_WIDTH + 20) + 200;

    // Group contents
    localparam int KIND_RANDOM = 0;
    localparam int KIND_ZERO   = 1;
    localparam int KIND_SAT    = 2;

    logic                           clk;
    logic                           rst_n;
    logic                           in_valid;
    logic                           in_ready;
    norm_stream_pkg::act_block_t    in_data;
    logic                           weight_valid;
    logic                           weight_ready;
    norm_stream_pkg::weight_block_t weight_data;
    logic                           out_valid;
    logic                           out_ready;
    norm_stream_pkg::out_block_t    out_data;

    integer seed;
    bit     in_gaps;
    bit     weight_gaps;
    bit     out_stalls;
    bit     reported;
    bit     passed;
    int     cycle_cnt;
    int     out_count;
    string  test_name;

    // Reference model queues
    norm_stream_pkg::act_block_t    group_buf[$];
    norm_stream_pkg::act_block_t    act_q[$];
    longint                         root_q[$];
    string                          name_q[$];
    norm_stream_pkg::weight_block_t weight_q[$];

    rms_norm_2d #(
        .NUM_ITERS  (NUM_ITERS),
        .FIFO_DEPTH (2 * NUM_ITERS)
    ) rms_norm_2d_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .weight_data  (weight_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data)
    );

    bind rms_norm_2d rms_norm_2d_props #(
        .DEPTH (FIFO_DEPTH)
    ) rms_norm_2d_props_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .fifo_out_valid (fifo_out_valid),
        .fifo_out_ready (fifo_out_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_data       (out_data)
    );

    // Floor of S times floor(2^22 / values per group), over 2^22
    function automatic longint group_mean(input norm_stream_pkg::act_block_t blocks[$]);
        longint sum;
        longint v;
        longint recip;
        sum = 0;
        foreach (blocks[b]) begin
            for (int i = 0; i < LANES; i++) begin
                v   = longint'($signed(blocks[b].lane[i]));
                sum = sum + v * v;
            end
        end
        recip = (longint'(1) << 22) / (LANES * NUM_ITERS);
        return (sum * recip) >>> 22;
    endfunction

    // Largest 16-bit R with R^2 * M at most 2^32, by binary search
    function automatic longint inv_root(input longint mean);
        longint lo;
        longint hi;
        longint mid;
        lo = 0;
        hi = 65535;
        while (lo < hi) begin
            mid = (lo + hi + 1) / 2;
            if (mid * mid * mean <= (longint'(1) << 32)) lo = mid;
            else hi = mid - 1;
        end
        return lo;
    endfunction

    function automatic logic [7:0] scale_lane(input logic [7:0] act, input longint root,
                                              input logic [7:0] weight);
        longint prod;
        prod = longint'($signed(act)) * root * longint'($signed(weight));
        prod = prod >>> 14;
        if (prod > 127) prod = 127;
        else if (prod < -128) prod = -128;
        return prod[7:0];
    endfunction

    function automatic norm_stream_pkg::out_block_t expected_block(
        input norm_stream_pkg::act_block_t a, input longint root,
        input norm_stream_pkg::weight_block_t w);
        norm_stream_pkg::out_block_t res;
        for (int i = 0; i < LANES; i++) begin
            res.lane[i] = scale_lane(a.lane[i], root, w.lane[i]);
        end
        return res;
    endfunction

    function automatic norm_stream_pkg::act_block_t make_act(input int kind);
        norm_stream_pkg::act_block_t blk;
        logic [7:0]                  mag;
        for (int i = 0; i < LANES; i++) begin
            mag = 8'd100 + 8'($random(seed) & 27);
            case (kind)
                KIND_ZERO: blk.lane[i] = '0;
                KIND_SAT:  blk.lane[i] = ($random(seed) & 1) ? -mag : mag;
                default:   blk.lane[i] = 8'($random(seed));
            endcase
        end
        return blk;
    endfunction

    // Saturation groups use the extreme weights on alternate lanes
    function automatic norm_stream_pkg::weight_block_t make_weight(input int kind);
        norm_stream_pkg::weight_block_t blk;
        for (int i = 0; i < LANES; i++) begin
            if (kind == KIND_SAT) blk.lane[i] = (i % 2 == 1) ? 8'h80 : 8'h7f;
            else blk.lane[i] = 8'($random(seed));
        end
        return blk;
    endfunction

    task automatic push_block(input norm_stream_pkg::act_block_t blk);
        while (in_gaps && ($random(seed) & 3) == 0) @(negedge clk);
        in_valid = 1'b1;
        in_data  = blk;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic push_weight(input norm_stream_pkg::weight_block_t blk);
        while (weight_gaps && ($random(seed) & 3) == 0) @(negedge clk);
        weight_valid = 1'b1;
        weight_data  = blk;
        @(posedge clk);
        while (!weight_ready) @(posedge clk);
        @(negedge clk);
        weight_valid = 1'b0;
    endtask

    task automatic stream_groups(input int kind, input int groups);
        for (int n = 0; n < groups * NUM_ITERS; n++) push_block(make_act(kind));
    endtask

    task automatic stream_weights(input int kind, input int groups);
        for (int n = 0; n < groups * NUM_ITERS; n++) push_weight(make_weight(kind));
    endtask

    task automatic run_phase(input string name, input int kind, input int groups,
                             input bit gaps, input bit stalls);
        test_name   = name;
        in_gaps     = gaps;
        weight_gaps = gaps;
        out_stalls  = stalls;
        fork
            stream_groups(kind, groups);
            stream_weights(kind, groups);
        join
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        out_ready = out_stalls ? (($random(seed) & 1) != 0) : 1'b1;
    end

    // Model update and output check on each transfer
    always @(posedge clk) begin : model_check
        longint                      root;
        norm_stream_pkg::out_block_t exp_blk;
        string                       exp_name;
        if (in_valid && in_ready) begin
            group_buf.push_back(in_data);
            if (group_buf.size() == NUM_ITERS) begin
                root = inv_root(group_mean(group_buf));
                foreach (group_buf[b]) begin
                    act_q.push_back(group_buf[b]);
                    root_q.push_back(root);
                    name_q.push_back(test_name);
                end
                group_buf.delete();
            end
        end
        if (weight_valid && weight_ready) weight_q.push_back(weight_data);
        if (out_valid && out_ready) begin
            if (act_q.size() == 0 || weight_q.size() == 0) begin
                $display("Output block arrived with no matching input group or weight");
                reported = 1'b1;
                $display("TB FAILED");
                $fatal(1, "unexpected output block");
            end else begin
                exp_blk  = expected_block(act_q.pop_front(), root_q.pop_front(),
                                          weight_q.pop_front());
                exp_name = name_q.pop_front();
                out_count++;
                assert (out_data == exp_blk) else begin
                    $display("Fail %s: expected %h actual %h", exp_name, exp_blk, out_data);
                    reported = 1'b1;
                    $display("TB FAILED");
                    $fatal(1, "output mismatch");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d blocks received",
                     cycle_cnt, out_count, TOTAL_BEATS);
            reported = 1'b1;
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed         = 72366;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        weight_valid = 1'b0;
        weight_data  = '0;
        out_ready    = 1'b1;
        in_gaps      = 1'b0;
        weight_gaps  = 1'b0;
        out_stalls   = 1'b0;
        reported     = 1'b0;
        passed       = 1'b0;
        cycle_cnt    = 0;
        out_count    = 0;
        test_name    = "reset";
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_phase("normal", KIND_RANDOM, 3, 1'b0, 1'b0);
        run_phase("zero_group", KIND_ZERO, 1, 1'b0, 1'b0);
        run_phase("after_zero", KIND_RANDOM, 1, 1'b0, 1'b0);
        run_phase("backpressure", KIND_RANDOM, 3, 1'b0, 1'b1);
        run_phase("input_stalls", KIND_RANDOM, 3, 1'b1, 1'b0);
        run_phase("saturation", KIND_SAT, 2, 1'b0, 1'b0);
        while (out_count < TOTAL_BEATS) @(posedge clk);
        repeat (5) @(negedge clk);
        if (act_q.size() == 0 && weight_q.size() == 0 && group_buf.size() == 0) begin
            passed = 1'b1;
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Model still holds blocks after the last output");
            reported = 1'b1;
            $display("TB FAILED");
            $fatal(1, "leftover blocks");
        end
    end

    // Run stopped by a property failure
    final begin
        if (!passed && !reported) $display("TB FAILED");
    end

endmodule
